/* verilog/dark_sub_macros.svh */
`ifndef DARK_SUB_MACROS_SVH
`define DARK_SUB_MACROS_SVH

// host channel and memory port
`define DS_MSG_W       32
`define DS_APP_DATA_W  64
`define DS_ADDR_W      27
`define DS_ADDR_INC    8   // one BL8 burst, two beats
`define DS_START_ADDR  0

// pixel datapath
`define DS_DN_W        12
`define DS_COEFF_W     16
`define DS_FIFO_DEPTH  16
`define DS_FIFO_HIGH   10

// capture counters
`define DS_ROW_W       11
`define DS_COL_W       11
`define DS_FRAME_W     20

`endif

/* verilog/dram_app_pkg.sv */
`default_nettype none

`include "dark_sub_macros.svh"

package dram_app_pkg;

  // command half of the controller app port
  typedef struct packed {
    logic                  en;
    logic                  read;   // 0 = write
    logic [`DS_ADDR_W-1:0] addr;
  } dram_cmd_t;

  // write data fifo side
  typedef struct packed {
    logic                      wren;
    logic                      last;  // app_wdf_end
    logic [`DS_APP_DATA_W-1:0] data;
  } dram_wdata_t;

  // read return, no flow control
  typedef struct packed {
    logic                      valid;
    logic [`DS_APP_DATA_W-1:0] data;
  } dram_rdata_t;

endpackage

`default_nettype wire

/* verilog/capture_pkg.sv */
`default_nettype none

`include "dark_sub_macros.svh"

package capture_pkg;

  typedef struct packed {
    logic                   kind;  // 1 for coefficient
    logic [14:0]            rsvd;
    logic [`DS_COEFF_W-1:0] coeff;
  } coeff_msg_t;

  typedef struct packed {
    logic                kind;  // 0 for pixel
    logic                fval;
    logic                lval;
    logic [16:0]         rsvd;
    logic [`DS_DN_W-1:0] dn;
  } pixel_msg_t;

  // same 32-bit word, decoded by the kind bit
  typedef union packed {
    coeff_msg_t coeff_view;
    pixel_msg_t pix_view;
  } host_msg_t;

  typedef struct packed {
    logic                   valid;
    logic [`DS_FRAME_W-1:0] frame;
    logic [`DS_ROW_W-1:0]   row;
    logic [`DS_COL_W-1:0]   col;
    logic [`DS_DN_W-1:0]    value;
  } pix_out_t;

  typedef enum logic [2:0] {
    CAP_STANDBY,
    CAP_INTRALINE,
    CAP_INTERLINE,
    CAP_INTERFRAME,
    CAP_ERROR
  } capture_state_t;

endpackage

`default_nettype wire

/* verilog/coeff_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dark_sub_macros.svh"

module coeff_fifo (
  input  wire logic                      dram_clk,
  input  wire logic                      reset,
  input  wire logic                      wr_en,
  input  wire logic [`DS_APP_DATA_W-1:0] din,
  input  wire logic                      rd_en,
  output logic      [`DS_APP_DATA_W-1:0] dout,
  output logic                           full,
  output logic                           high,
  output logic                           empty
);

  localparam int PTR_W = $clog2(`DS_FIFO_DEPTH);

  logic [`DS_APP_DATA_W-1:0] mem [`DS_FIFO_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W:0]            count;
  logic                      do_wr;
  logic                      do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // first word fall-through
  assign dout  = mem[rd_ptr];
  assign full  = count == (PTR_W + 1)'(`DS_FIFO_DEPTH);
  assign empty = count == '0;
  assign high  = count >= (PTR_W + 1)'(`DS_FIFO_HIGH);

  always_ff @(posedge dram_clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read throttling upstream must keep the in-flight beats below full
  a_no_write_when_full: assert property (
    @(posedge dram_clk) disable iff (reset) full |-> !wr_en
  );

endmodule

`default_nettype wire

/* verilog/dram_coeff_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dark_sub_macros.svh"

module dram_coeff_ctrl
  import dram_app_pkg::*;
  import capture_pkg::*;
(
  input  wire logic        dram_clk,
  input  wire logic        reset,
  input  wire logic        msg_pending,
  input  wire host_msg_t   msg,
  output logic             msg_ack,
  output logic             accepted_pixel,
  input  wire logic        app_rdy,
  output dram_cmd_t        dram_cmd,
  input  wire logic        app_wdf_rdy,
  output dram_wdata_t      dram_wdata,
  input  wire logic        fifo_full,
  input  wire logic        fifo_high,
  input  wire logic        frame_gap,
  output logic             ctrl_error
);

  typedef enum logic [2:0] {
    S_MSG_WAIT,
    S_WR_WAIT,
    S_WR1,
    S_WR2,
    S_READING,
    S_THROTTLED,
    S_INTERFRAME,
    S_ERROR
  } ctrl_state_t;

  ctrl_state_t                 state;
  logic [2*`DS_APP_DATA_W-1:0] stage;
  logic [2:0]                  coeff_idx;
  logic [`DS_ADDR_W-1:0]       end_addr;
  logic [`DS_ADDR_W-1:0]       rd_addr_next;
  logic                        rearm;
  logic                        is_coeff;
  logic                        may_take;
  logic                        accept;

  assign is_coeff = msg.coeff_view.kind;
  // coefficients only between bursts, pixels anywhere but mid-write
  assign may_take = is_coeff ? (state == S_MSG_WAIT)
                             : !(state inside {S_WR1, S_WR2, S_ERROR});
  assign accept         = msg_pending && !msg_ack && may_take;
  assign accepted_pixel = accept && !is_coeff;
  assign ctrl_error     = state == S_ERROR;

  // address of the next read once the pending command is taken
  assign rd_addr_next = dram_cmd.en ? dram_cmd.addr + `DS_ADDR_INC : dram_cmd.addr;

  always_ff @(posedge dram_clk) begin
    if (accept && is_coeff) stage[coeff_idx*`DS_COEFF_W +: `DS_COEFF_W] <= msg.coeff_view.coeff;
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      state           <= S_MSG_WAIT;
      msg_ack         <= 1'b0;
      coeff_idx       <= '0;
      end_addr        <= `DS_START_ADDR;
      rearm           <= 1'b0;
      dram_cmd.en     <= 1'b0;
      dram_cmd.read   <= 1'b0;
      dram_cmd.addr   <= `DS_START_ADDR;
      dram_wdata.wren <= 1'b0;
      dram_wdata.last <= 1'b1;
    end else begin
      msg_ack <= accept;
      if (!frame_gap) rearm <= 1'b1;

      if (fifo_full && state != S_ERROR) begin
        dram_cmd.en <= 1'b0;
        state       <= S_ERROR;
      end else begin
        case (state)
          S_MSG_WAIT:
            if (accept && !is_coeff) begin  // first pixel, start pass 1
              dram_cmd.addr <= `DS_START_ADDR;
              dram_cmd.read <= 1'b1;
              dram_cmd.en   <= end_addr != `DS_START_ADDR;
              rearm         <= 1'b0;
              state         <= (end_addr != `DS_START_ADDR) ? S_READING : S_INTERFRAME;
            end else if (accept) begin
              coeff_idx <= coeff_idx + 1'b1;
              if (coeff_idx == 3'd7) begin
                dram_cmd.en     <= 1'b1;
                dram_cmd.read   <= 1'b0;
                dram_wdata.wren <= 1'b1;
                dram_wdata.last <= 1'b0;
                dram_wdata.data <= stage[0 +: `DS_APP_DATA_W];
                state           <= S_WR1;
              end
            end
          S_WR1: begin
            if (app_rdy) dram_cmd.en <= 1'b0;
            if (app_wdf_rdy) begin
              dram_wdata.last <= 1'b1;
              dram_wdata.data <= stage[`DS_APP_DATA_W +: `DS_APP_DATA_W];
              state           <= S_WR2;
            end
          end
          S_WR2: begin
            if (app_rdy) dram_cmd.en <= 1'b0;
            dram_wdata.wren <= 1'b0;
            if (!app_wdf_rdy) state <= S_ERROR;  // second beat refused
            else if (dram_cmd.en && !app_rdy) state <= S_WR_WAIT;
            else begin
              dram_cmd.addr <= dram_cmd.addr + `DS_ADDR_INC;
              end_addr      <= end_addr + `DS_ADDR_INC;
              state         <= S_MSG_WAIT;
            end
          end
          S_WR_WAIT:
            if (app_rdy) begin
              dram_cmd.en   <= 1'b0;
              dram_cmd.addr <= dram_cmd.addr + `DS_ADDR_INC;
              end_addr      <= end_addr + `DS_ADDR_INC;
              state         <= S_MSG_WAIT;
            end
          S_READING:
            if (!dram_cmd.en || app_rdy) begin
              dram_cmd.addr <= rd_addr_next;
              if (rd_addr_next == end_addr) begin
                dram_cmd.en <= 1'b0;
                state       <= S_INTERFRAME;
              end else if (fifo_high) begin
                dram_cmd.en <= 1'b0;
                state       <= S_THROTTLED;
              end else begin
                dram_cmd.en <= 1'b1;
              end
            end
          S_THROTTLED:
            if (!fifo_high) begin
              dram_cmd.en <= 1'b1;
              state       <= S_READING;
            end
          S_INTERFRAME:
            if (frame_gap && rearm) begin  // once per gap
              dram_cmd.addr <= `DS_START_ADDR;
              dram_cmd.en   <= 1'b1;
              rearm         <= 1'b0;
              state         <= S_READING;
            end
          default: ;  // error holds
        endcase
      end
    end
  end

  // throttle at the high mark leaves room for the reads in flight
  a_no_full_while_reading: assert property (
    @(posedge dram_clk) disable iff (reset) state == S_READING |-> !fifo_full
  );

endmodule

`default_nettype wire

/* verilog/capture_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dark_sub_macros.svh"

// idle cycles arrive as lval without fval, which no real pixel carries
module capture_tracker
  import capture_pkg::*;
(
  input  wire logic                   dram_clk,
  input  wire logic                   reset,
  input  wire logic                   fval,
  input  wire logic                   lval,
  input  wire logic                   fifo_empty,
  output logic      [`DS_FRAME_W-1:0] frame,
  output logic      [`DS_ROW_W-1:0]   row,
  output logic      [`DS_COL_W-1:0]   col,
  output logic                        frame_gap,
  output logic                        underrun
);

  capture_state_t state;
  logic           pix;
  logic           line_gap;
  logic           frame_end;

  assign pix       = fval && lval;
  assign line_gap  = fval && !lval;
  assign frame_end = !fval && !lval;

  assign frame_gap = state == CAP_INTERFRAME;
  assign underrun  = state == CAP_ERROR;

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      state <= CAP_STANDBY;
      frame <= '0;
      row   <= '0;
      col   <= '0;
    end else if (pix && fifo_empty && state != CAP_ERROR) begin
      state <= CAP_ERROR;  // no coefficient for this pixel
    end else begin
      case (state)
        CAP_STANDBY:
          if (pix) begin
            frame <= '0;
            row   <= '0;
            col   <= '0;
            state <= CAP_INTRALINE;
          end
        CAP_INTRALINE:
          if (pix) col <= col + 1'b1;
          else if (line_gap) state <= CAP_INTERLINE;
          else if (frame_end) state <= CAP_INTERFRAME;
        CAP_INTERLINE:
          if (pix) begin
            row   <= row + 1'b1;
            col   <= '0;
            state <= CAP_INTRALINE;
          end else if (frame_end) begin
            state <= CAP_INTERFRAME;
          end
        CAP_INTERFRAME:
          if (pix) begin
            frame <= frame + 1'b1;
            row   <= '0;
            col   <= '0;
            state <= CAP_INTRALINE;
          end
        default: ;  // locked until reset
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/pixel_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dark_sub_macros.svh"

module pixel_pipe
  import capture_pkg::*;
(
  input  wire logic                      dram_clk,
  input  wire logic                      reset,
  input  wire logic                      accepted_pixel,
  input  wire host_msg_t                 msg,
  input  wire logic [`DS_APP_DATA_W-1:0] coeff_beat,
  input  wire logic                      fifo_empty,
  output logic                           fifo_pop,
  output logic                           frame_gap,
  output pix_out_t                       pix_out,
  output logic                           underrun
);

  logic                   s1_fval;
  logic                   s1_lval;
  logic [`DS_DN_W-1:0]    s1_dn;
  logic                   pix;
  logic [1:0]             lane;
  logic [`DS_COEFF_W-1:0] coeff;
  logic                   s2_valid;
  logic [`DS_DN_W-1:0]    s2_value;
  logic [`DS_FRAME_W-1:0] frame;
  logic [`DS_ROW_W-1:0]   row;
  logic [`DS_COL_W-1:0]   col;

  // stage 1, non-message cycles look like idle (lval without fval)
  always_ff @(posedge dram_clk) begin
    if (reset) begin
      s1_fval <= 1'b0;
      s1_lval <= 1'b1;
      s1_dn   <= '0;
    end else begin
      s1_fval <= accepted_pixel && msg.pix_view.fval;
      s1_lval <= !accepted_pixel || msg.pix_view.lval;
      s1_dn   <= msg.pix_view.dn;
    end
  end

  assign pix = s1_fval && s1_lval;

  assign coeff    = coeff_beat[lane*`DS_COEFF_W +: `DS_COEFF_W];
  assign fifo_pop = pix && !fifo_empty && lane == 2'd3;

  capture_tracker i_capture_tracker (
    .dram_clk   (dram_clk),
    .reset      (reset),
    .fval       (s1_fval),
    .lval       (s1_lval),
    .fifo_empty (fifo_empty),
    .frame      (frame),
    .row        (row),
    .col        (col),
    .frame_gap  (frame_gap),
    .underrun   (underrun)
  );

  // stage 2, tracker counters move on at the same edge
  always_ff @(posedge dram_clk) begin
    if (reset) begin
      lane     <= '0;
      s2_valid <= 1'b0;
      s2_value <= '0;
    end else begin
      s2_valid <= pix && !fifo_empty && !underrun;
      if (pix && !fifo_empty) begin
        lane     <= lane + 1'b1;
        s2_value <= (`DS_COEFF_W'(s1_dn) > coeff) ? s1_dn - `DS_DN_W'(coeff) : '0;
      end
    end
  end

  // stage 3, value tagged with its position
  always_ff @(posedge dram_clk) begin
    if (reset) begin
      pix_out <= '0;
    end else begin
      pix_out.valid <= s2_valid;
      pix_out.frame <= frame;
      pix_out.row   <= row;
      pix_out.col   <= col;
      pix_out.value <= s2_value;
    end
  end

endmodule

`default_nettype wire

/* verilog/dark_sub_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dark_sub_macros.svh"

module dark_sub_top
  import dram_app_pkg::*;
  import capture_pkg::*;
(
  input  wire logic        dram_clk,
  input  wire logic        reset,
  input  wire logic        msg_pending,
  input  wire host_msg_t   msg,
  output logic             msg_ack,
  input  wire logic        app_rdy,
  output dram_cmd_t        dram_cmd,
  input  wire logic        app_wdf_rdy,
  output dram_wdata_t      dram_wdata,
  input  wire dram_rdata_t dram_rdata,
  output pix_out_t         pix_out,
  output logic             error
);

  logic                      accepted_pixel;
  logic                      fifo_full;
  logic                      fifo_high;
  logic                      fifo_empty;
  logic                      fifo_pop;
  logic                      frame_gap;
  logic                      ctrl_error;
  logic                      underrun;
  logic [`DS_APP_DATA_W-1:0] coeff_beat;

  // full is one of the three error sources
  assign error = ctrl_error || fifo_full || underrun;

  dram_coeff_ctrl i_dram_coeff_ctrl (
    .dram_clk       (dram_clk),
    .reset          (reset),
    .msg_pending    (msg_pending),
    .msg            (msg),
    .msg_ack        (msg_ack),
    .accepted_pixel (accepted_pixel),
    .app_rdy        (app_rdy),
    .dram_cmd       (dram_cmd),
    .app_wdf_rdy    (app_wdf_rdy),
    .dram_wdata     (dram_wdata),
    .fifo_full      (fifo_full),
    .fifo_high      (fifo_high),
    .frame_gap      (frame_gap),
    .ctrl_error     (ctrl_error)
  );

  coeff_fifo i_coeff_fifo (
    .dram_clk (dram_clk),
    .reset    (reset),
    .wr_en    (dram_rdata.valid),  // flow control is the read throttle
    .din      (dram_rdata.data),
    .rd_en    (fifo_pop),
    .dout     (coeff_beat),
    .full     (fifo_full),
    .high     (fifo_high),
    .empty    (fifo_empty)
  );

  pixel_pipe i_pixel_pipe (
    .dram_clk       (dram_clk),
    .reset          (reset),
    .accepted_pixel (accepted_pixel),
    .msg            (msg),
    .coeff_beat     (coeff_beat),
    .fifo_empty     (fifo_empty),
    .fifo_pop       (fifo_pop),
    .frame_gap      (frame_gap),
    .pix_out        (pix_out),
    .underrun       (underrun)
  );

endmodule

`default_nettype wire

/* verif/dram_app_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dark_sub_macros.svh"

// app-port DRAM, a read command returns its whole two-beat burst
module dram_app_model
  import dram_app_pkg::*;
(
  input  wire logic        dram_clk,
  input  wire logic        reset,
  input  wire dram_cmd_t   dram_cmd,
  output logic             app_rdy,
  input  wire dram_wdata_t dram_wdata,
  output logic             app_wdf_rdy,
  output dram_rdata_t      dram_rdata
);

  localparam int READ_LAT = 4;

  logic [`DS_APP_DATA_W-1:0] mem [int];  // key is addr*2 + beat
  logic [`DS_APP_DATA_W-1:0] wr_beats [$];
  int                        wr_addrs [$];
  logic [`DS_APP_DATA_W-1:0] rd_beats [$];
  longint                    rd_due [$];
  longint                    cycle;
  int                        seed;
  int                        key;
  logic                      beat0_taken;

  function automatic logic [`DS_APP_DATA_W-1:0] fill_word(input int k);
    return {k, ~k} ^ 64'h5a5a_0f0f_c3c3_9696;  // unwritten locations
  endfunction

  initial begin
    seed        = 32'h42be0cc6;
    cycle       = 0;
    app_rdy     = 1'b1;
    app_wdf_rdy = 1'b1;
    dram_rdata  = '0;
  end

  always @(posedge dram_clk) begin
    cycle++;
    beat0_taken = dram_wdata.wren && app_wdf_rdy && !dram_wdata.last;
    if (reset) begin
      wr_beats.delete();
      wr_addrs.delete();
      rd_beats.delete();
      rd_due.delete();
    end else begin
      if (dram_wdata.wren && app_wdf_rdy) wr_beats.push_back(dram_wdata.data);
      if (dram_cmd.en && app_rdy && !dram_cmd.read) wr_addrs.push_back(int'(dram_cmd.addr));
      if (dram_cmd.en && app_rdy && dram_cmd.read) begin
        for (int b = 0; b < 2; b++) begin
          key = int'(dram_cmd.addr) * 2 + b;
          rd_beats.push_back(mem.exists(key) ? mem[key] : fill_word(key));
          rd_due.push_back(cycle + READ_LAT);
        end
      end
      // command and beats may be taken in either order
      while (wr_addrs.size() > 0 && wr_beats.size() >= 2) begin
        key          = wr_addrs.pop_front() * 2;
        mem[key]     = wr_beats.pop_front();
        mem[key + 1] = wr_beats.pop_front();
      end
    end
    #1;
    dram_rdata.valid = 1'b0;
    if (!reset && rd_beats.size() > 0 && rd_due[0] <= cycle) begin
      dram_rdata.valid = 1'b1;
      dram_rdata.data  = rd_beats.pop_front();
      void'(rd_due.pop_front());
    end
    app_rdy     = ($random(seed) & 3) != 0;
    app_wdf_rdy = beat0_taken || (($random(seed) & 3) != 0);  // beat 2 never stalled
  end

endmodule

`default_nettype wire

/* verif/tb_dark_sub.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dark_sub_macros.svh"

module tb_dark_sub
  import dram_app_pkg::*;
  import capture_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int ROWS        = 3;
  localparam int COLS        = 8;
  localparam int N_COEFF     = ROWS * COLS;
  localparam int N_BURSTS    = N_COEFF / 8;
  localparam int IDLE        = 20;  // read pass lands before the first line
  localparam int HOST_GAP    = 2;   // slowed host
  localparam int N_MSGS      = N_COEFF + 2 * (1 + ROWS * (COLS + 1)) + 1;
  localparam int WATCHDOG_NS = N_MSGS * 2 * CLK_PERIOD * 4;

  logic                   dram_clk;
  logic                   reset;
  logic                   msg_pending;
  host_msg_t              msg;
  logic                   msg_ack;
  logic                   app_rdy;
  dram_cmd_t              dram_cmd;
  logic                   app_wdf_rdy;
  dram_wdata_t            dram_wdata;
  dram_rdata_t            dram_rdata;
  pix_out_t               pix_out;
  logic                   error;
  logic                   expect_error;
  int                     errors;
  int                     mismatches;
  logic [`DS_COEFF_W-1:0] coeff_tab [N_COEFF];
  pix_out_t               exp_q [$];

  dark_sub_top i_dark_sub_top (.*);
  dram_app_model dram_model (.*);

  initial dram_clk = 1'b0;
  always #(CLK_PERIOD / 2) dram_clk = ~dram_clk;

  function automatic host_msg_t coeff_msg(input logic [`DS_COEFF_W-1:0] c);
    host_msg_t m;
    m = '0;
    m.coeff_view.kind  = 1'b1;
    m.coeff_view.coeff = c;
    return m;
  endfunction

  function automatic host_msg_t pixel_msg(input logic fval, input logic lval,
                                          input logic [`DS_DN_W-1:0] dn);
    host_msg_t m;
    m = '0;
    m.pix_view.fval = fval;
    m.pix_view.lval = lval;
    m.pix_view.dn   = dn;
    return m;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge dram_clk);
      #1;
    end
  endtask

  task automatic compare_value(input string what, input int got, input int exp);
    assert (got == exp) else begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // hold pending until ack, then at least one cycle low
  task automatic send_msg(input host_msg_t m);
    msg_pending = 1'b1;
    msg         = m;
    do idle_cycles(1); while (!msg_ack);
    msg_pending = 1'b0;
    idle_cycles(1 + HOST_GAP);
  endtask

  task automatic check_bursts();
    logic [`DS_APP_DATA_W-1:0] want;
    int key;
    key = (N_BURSTS - 1) * `DS_ADDR_INC * 2 + 1;
    for (int i = 0; i < 50 && !dram_model.mem.exists(key); i++) idle_cycles(1);
    for (int b = 0; b < N_BURSTS; b++) begin
      for (int beat = 0; beat < 2; beat++) begin
        key = b * `DS_ADDR_INC * 2 + beat;
        for (int lane = 0; lane < 4; lane++)
          want[lane*`DS_COEFF_W +: `DS_COEFF_W] = coeff_tab[b*8 + beat*4 + lane];
        if (!dram_model.mem.exists(key)) begin
          errors++;
          $display("burst %0d beat %0d never reached the DRAM model", b, beat);
        end else begin
          assert (dram_model.mem[key] == want) else begin
            mismatches++;
            $display("MISMATCH at %0t: burst %0d beat %0d holds %h, expected %h",
                     $time, b, beat, dram_model.mem[key], want);
          end
        end
      end
    end
  endtask

  task automatic send_frame(input int f);
    pix_out_t             exp;
    logic [`DS_DN_W-1:0]  dn;
    int                   k;
    int                   diff;
    send_msg(pixel_msg(1'b1, 1'b0, '0));  // frame start
    idle_cycles(IDLE);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        k         = r * COLS + c;
        dn        = `DS_DN_W'((k * 29 + f * 131 + 60) % 4096);
        diff      = int'(dn) - int'(coeff_tab[k]);
        exp.valid = 1'b1;
        exp.frame = `DS_FRAME_W'(f);
        exp.row   = `DS_ROW_W'(r);
        exp.col   = `DS_COL_W'(c);
        exp.value = (diff > 0) ? `DS_DN_W'(diff) : '0;  // clamp at zero
        exp_q.push_back(exp);
        send_msg(pixel_msg(1'b1, 1'b1, dn));
      end
      send_msg(pixel_msg(r != ROWS - 1, 1'b0, '0));  // line gap, frame end after last row
    end
  endtask

  always @(negedge dram_clk) begin
    pix_out_t want;
    if (!reset && !expect_error && pix_out.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("output pixel at %0t with nothing expected", $time);
      end else begin
        want = exp_q.pop_front();
        compare_value("value", int'(pix_out.value), int'(want.value));
        compare_value("frame", int'(pix_out.frame), int'(want.frame));
        compare_value("row", int'(pix_out.row), int'(want.row));
        compare_value("col", int'(pix_out.col), int'(want.col));
      end
    end
  end

  // ack trails acceptance by one cycle, the pipe takes three
  a_pixel_latency: assert property (
    @(negedge dram_clk) disable iff (reset || expect_error)
      pix_out.valid |-> $past(msg_ack && !msg.pix_view.kind && msg.pix_view.fval
                              && msg.pix_view.lval, 2)
  ) else begin
    errors++;
    $display("output pixel at %0t is not two cycles after a line pixel ack", $time);
  end

  // covers fifo overflow too, full feeds error
  a_error_low: assert property (
    @(negedge dram_clk) disable iff (reset || expect_error) !error
  ) else begin
    errors++;
    $display("error output went high at %0t with coefficients stored", $time);
  end

  a_error_sticky: assert property (
    @(negedge dram_clk) disable iff (reset) error |=> error
  ) else begin
    errors++;
    $display("error output dropped at %0t without a reset", $time);
  end

  initial begin
    reset        = 1'b1;
    msg_pending  = 1'b0;
    msg          = '0;
    expect_error = 1'b0;
    errors       = 0;
    mismatches   = 0;
    for (int k = 0; k < N_COEFF; k++)
      coeff_tab[k] = (k == 5) ? 16'hf000 : `DS_COEFF_W'((k * 53) % 400);
    repeat (2) @(posedge dram_clk);
    #1;
    reset = 1'b0;
    compare_value("msg_ack after reset", int'(msg_ack), 0);
    compare_value("cmd en after reset", int'(dram_cmd.en), 0);
    compare_value("wren after reset", int'(dram_wdata.wren), 0);
    compare_value("wdf last after reset", int'(dram_wdata.last), 1);
    compare_value("pix valid after reset", int'(pix_out.valid), 0);
    compare_value("error after reset", int'(error), 0);

    for (int k = 0; k < N_COEFF; k++) send_msg(coeff_msg(coeff_tab[k]));
    check_bursts();
    send_frame(0);
    send_frame(1);  // same coefficients again from address 0
    for (int i = 0; i < 20 && exp_q.size() > 0; i++) idle_cycles(1);
    if (exp_q.size() > 0) begin
      errors++;
      $display("%0d expected pixels never came out", exp_q.size());
    end

    // nothing stored, so the first line pixel underruns
    expect_error = 1'b1;
    reset        = 1'b1;
    idle_cycles(2);
    reset = 1'b0;
    send_msg(pixel_msg(1'b1, 1'b1, 12'h123));
    for (int i = 0; i < 20 && !error; i++) idle_cycles(1);
    if (!error) begin
      errors++;
      $display("error did not rise on a pixel with no stored coefficients");
    end
    for (int i = 0; i < 10; i++) begin
      idle_cycles(1);
      compare_value("error after underrun", int'(error), 1);
    end

    $display("errors=%0d mismatches=%0d", errors, mismatches);
    if (errors == 0 && mismatches == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/dram_app_pkg.sv
verilog/capture_pkg.sv
verilog/coeff_fifo.sv
verilog/dram_coeff_ctrl.sv
verilog/capture_tracker.sv
verilog/pixel_pipe.sv
verilog/dark_sub_top.sv
verif/dram_app_model.sv
verif/tb_dark_sub.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dark_sub
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# pass only when the testbench printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
